// ==== dv/shell_tb.sv ====
`timescale 1ns/100ps
`default_nettype none

module shell_tb;

    localparam int WAIT_LIMIT = 200;

    logic clk = 1'b0;
    logic rst;

    logic [shell_pkg::SHELL_TO_CORE_WID-1:0] shell_to_core;
    logic [shell_pkg::CORE_TO_SHELL_WID-1:0] core_to_shell;
    shell_pkg::shell_to_core_t               drv;
    shell_pkg::core_to_shell_t               mon;

    int          mismatch_count = 0;
    int          fail_count = 0;
    logic [31:0] rng_state = 32'h30dc;

    assign shell_to_core = drv;
    assign mon           = core_to_shell;

    always #2 clk = ~clk;

    shell_adapter u_shell_adapter (
        .clk           ( clk ),
        .rst           ( rst ),
        .shell_to_core ( shell_to_core ),
        .core_to_shell ( core_to_shell )
    );

    // --------------------
    // Helpers
    // --------------------
    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic logic [31:0] next_rand();
        rng_state = xorshift32(rng_state);
        return rng_state;
    endfunction

    function automatic string path_name(input bit dma);
        if (dma) begin
            return "DMA";
        end
        return "CMAC";
    endfunction

    task automatic stop_on_timeout(input string what);
        $display("ERROR at %0t: timed out waiting for %s", $time, what);
        $display("Errors: %0d mismatches, %0d other failures", mismatch_count, fail_count + 1);
        $display("TEST RESULT: FAIL");
        $finish;
    endtask

    task automatic check_data(input shell_pkg::axil_data_t got, input shell_pkg::axil_data_t exp,
                              input string what);
        if (got !== exp) begin
            $display("MISMATCH at %0t: %s data got %h expected %h", $time, what, got, exp);
            mismatch_count++;
        end
    endtask

    task automatic check_resp(input shell_pkg::axil_resp_t got, input shell_pkg::axil_resp_t exp,
                              input string what);
        if (got !== exp) begin
            $display("MISMATCH at %0t: %s response got %0d expected %0d", $time, what, got, exp);
            mismatch_count++;
        end
    endtask

    task automatic check_beat(input shell_pkg::axis_fwd_t got, input shell_pkg::axis_fwd_t exp,
                              input string what);
        if (got !== exp) begin
            $display("MISMATCH at %0t: %s got %h expected %h", $time, what, got, exp);
            mismatch_count++;
        end
    endtask

    // --------------------
    // AXI-Lite
    // --------------------
    task automatic axil_write(input shell_pkg::axil_addr_t addr, input shell_pkg::axil_data_t data,
                              input shell_pkg::axil_strb_t strb,
                              output shell_pkg::axil_resp_t resp);
        int waited;
        drv.axil.awvalid <= 1'b1;
        drv.axil.awaddr  <= addr;
        drv.axil.awprot  <= '0;
        drv.axil.wvalid  <= 1'b1;
        drv.axil.wdata   <= data;
        drv.axil.wstrb   <= strb;
        drv.axil.bready  <= 1'b1;
        waited = 0;
        do begin
            @(posedge clk);
            waited++;
            if (mon.axil.awready !== mon.axil.wready) begin
                $display("ERROR at %0t: awready and wready did not rise together", $time);
                fail_count++;
            end
            if (waited > WAIT_LIMIT) begin
                stop_on_timeout("awready and wready");
            end
        end while (!(mon.axil.awready && mon.axil.wready));
        drv.axil.awvalid <= 1'b0;
        drv.axil.wvalid  <= 1'b0;
        waited = 0;
        do begin
            @(posedge clk);
            waited++;
            if (waited > WAIT_LIMIT) begin
                stop_on_timeout("bvalid");
            end
        end while (!mon.axil.bvalid);
        resp = mon.axil.bresp;
        drv.axil.bready <= 1'b0;
    endtask

    task automatic axil_read(input shell_pkg::axil_addr_t addr, output shell_pkg::axil_data_t data,
                             output shell_pkg::axil_resp_t resp);
        int waited;
        drv.axil.arvalid <= 1'b1;
        drv.axil.araddr  <= addr;
        drv.axil.arprot  <= '0;
        drv.axil.rready  <= 1'b1;
        waited = 0;
        do begin
            @(posedge clk);
            waited++;
            if (waited > WAIT_LIMIT) begin
                stop_on_timeout("arready");
            end
        end while (!mon.axil.arready);
        drv.axil.arvalid <= 1'b0;
        waited = 0;
        do begin
            @(posedge clk);
            waited++;
            if (waited > WAIT_LIMIT) begin
                stop_on_timeout("rvalid");
            end
        end while (!mon.axil.rvalid);
        data = mon.axil.rdata;
        resp = mon.axil.rresp;
        drv.axil.rready <= 1'b0;
    endtask

    task automatic write_check(input shell_pkg::axil_addr_t addr, input shell_pkg::axil_data_t data,
                               input shell_pkg::axil_strb_t strb,
                               input shell_pkg::axil_resp_t exp_resp, input string what);
        shell_pkg::axil_resp_t resp;
        axil_write(addr, data, strb, resp);
        check_resp(resp, exp_resp, what);
    endtask

    task automatic read_check(input shell_pkg::axil_addr_t addr,
                              input shell_pkg::axil_data_t exp_data,
                              input shell_pkg::axil_resp_t exp_resp, input string what);
        shell_pkg::axil_data_t data;
        shell_pkg::axil_resp_t resp;
        axil_read(addr, data, resp);
        check_data(data, exp_data, what);
        check_resp(resp, exp_resp, what);
    endtask

    // --------------------
    // Streams
    // --------------------
    task automatic make_packet(input int len, output shell_pkg::axis_fwd_t beats[$]);
        shell_pkg::axis_fwd_t beat;
        logic [31:0]          r;
        beats.delete();
        for (int i = 0; i < len; i++) begin
            r           = next_rand();
            beat.tvalid = 1'b1;
            beat.tdata  = {next_rand(), next_rand()};
            beat.tkeep  = r[7:0];
            beat.tuser  = r[8];
            beat.tlast  = (i == len - 1);
            beats.push_back(beat);
        end
    endtask

    task automatic drive_in(input bit dma, input shell_pkg::axis_fwd_t beat);
        if (dma) begin
            drv.h2c <= beat;
        end else begin
            drv.cmac_rx <= beat;
        end
    endtask

    task automatic drive_out_ready(input bit dma, input logic ready);
        if (dma) begin
            drv.c2h.tready <= ready;
        end else begin
            drv.cmac_tx.tready <= ready;
        end
    endtask

    task automatic send_packet(input bit dma, input shell_pkg::axis_fwd_t beats[$]);
        int   waited;
        logic ready;
        foreach (beats[i]) begin
            drive_in(dma, beats[i]);
            waited = 0;
            do begin
                @(posedge clk);
                waited++;
                ready = dma ? mon.h2c.tready : mon.cmac_rx.tready;
                if (waited > WAIT_LIMIT) begin
                    stop_on_timeout({path_name(dma), " input tready"});
                end
            end while (!ready);
        end
        drive_in(dma, '0);
    endtask

    task automatic collect_packet(input bit dma, input bit random_ready,
                                  output shell_pkg::axis_fwd_t beats[$]);
        shell_pkg::axis_fwd_t beat;
        logic                 ready;
        logic                 done;
        logic [31:0]          r;
        int                   idle;
        beats.delete();
        done = 1'b0;
        idle = 0;
        while (!done) begin
            @(posedge clk);
            beat  = dma ? mon.c2h : mon.cmac_tx;
            ready = dma ? drv.c2h.tready : drv.cmac_tx.tready;
            if (beat.tvalid && ready) begin
                beats.push_back(beat);
                done = beat.tlast;
                idle = 0;
            end else begin
                idle++;
                if (idle > WAIT_LIMIT) begin
                    stop_on_timeout({path_name(dma), " output beat"});
                end
            end
            r = random_ready ? next_rand() : 32'h1;
            drive_out_ready(dma, r[0]);
        end
        drive_out_ready(dma, 1'b1);
    endtask

    task automatic compare_packet(input shell_pkg::axis_fwd_t got[$],
                                  input shell_pkg::axis_fwd_t exp[$], input string what);
        if (got.size() != exp.size()) begin
            $display("ERROR at %0t: %s returned %0d beats but %0d were sent",
                     $time, what, got.size(), exp.size());
            fail_count++;
        end
        for (int i = 0; i < exp.size() && i < got.size(); i++) begin
            check_beat(got[i], exp[i], $sformatf("%s beat %0d", what, i));
        end
    endtask

    task automatic check_out_idle(input bit dma);
        logic valid;
        valid = dma ? mon.c2h.tvalid : mon.cmac_tx.tvalid;
        if (valid) begin
            $display("ERROR at %0t: %s output sent a beat while its path was disabled",
                     $time, path_name(dma));
            fail_count++;
        end
    endtask

    // Output must stay silent while the packet goes in, plus the path latency
    task automatic send_expect_dropped(input bit dma, input shell_pkg::axis_fwd_t beats[$]);
        logic sent;
        sent = 1'b0;
        fork
            begin
                send_packet(dma, beats);
                sent = 1'b1;
            end
            begin
                while (!sent) begin
                    @(posedge clk);
                    check_out_idle(dma);
                end
            end
        join
        repeat (2) begin
            @(posedge clk);
            check_out_idle(dma);
        end
    endtask

    // --------------------
    // Tests
    // --------------------
    task automatic test_registers();
        read_check(shell_pkg::REG_ID, 32'h5348_0001, shell_pkg::RESP_OKAY, "ID");
        read_check(shell_pkg::REG_CONTROL, 32'h3, shell_pkg::RESP_OKAY, "control after reset");
        read_check(shell_pkg::REG_CMAC_FWD, 32'h0, shell_pkg::RESP_OKAY, "CMAC fwd after reset");
        read_check(shell_pkg::REG_CMAC_DROP, 32'h0, shell_pkg::RESP_OKAY, "CMAC drop after reset");
        read_check(shell_pkg::REG_DMA_FWD, 32'h0, shell_pkg::RESP_OKAY, "DMA fwd after reset");
        read_check(shell_pkg::REG_DMA_DROP, 32'h0, shell_pkg::RESP_OKAY, "DMA drop after reset");
        read_check(shell_pkg::REG_SCRATCH, 32'h0, shell_pkg::RESP_OKAY, "scratch after reset");
        write_check(shell_pkg::REG_SCRATCH, 32'h1122_3344, 4'hF, shell_pkg::RESP_OKAY, "scratch wr");
        write_check(shell_pkg::REG_SCRATCH, 32'hAABB_CCDD, 4'b0101, shell_pkg::RESP_OKAY,
                    "scratch partial wr");
        read_check(shell_pkg::REG_SCRATCH, 32'h11BB_33DD, shell_pkg::RESP_OKAY, "scratch merged");
        write_check(shell_pkg::REG_SCRATCH, 32'h5566_7788, 4'b1000, shell_pkg::RESP_OKAY,
                    "scratch top byte wr");
        read_check(shell_pkg::REG_SCRATCH, 32'h55BB_33DD, shell_pkg::RESP_OKAY, "scratch top byte");
    endtask

    task automatic test_error_responses();
        write_check(8'h0C, 32'hFFFF_FFFF, 4'hF, shell_pkg::RESP_SLVERR, "unmapped write");
        write_check(8'h40, 32'h1234_5678, 4'hF, shell_pkg::RESP_SLVERR, "unmapped write high");
        write_check(shell_pkg::REG_ID, 32'hDEAD_BEEF, 4'hF, shell_pkg::RESP_SLVERR, "ID write");
        write_check(shell_pkg::REG_CMAC_FWD, 32'h7, 4'hF, shell_pkg::RESP_SLVERR, "counter write");
        read_check(shell_pkg::REG_ID, 32'h5348_0001, shell_pkg::RESP_OKAY, "ID after write");
        read_check(shell_pkg::REG_CMAC_FWD, 32'h0, shell_pkg::RESP_OKAY, "counter after write");
        read_check(8'h0C, 32'h0, shell_pkg::RESP_SLVERR, "unmapped read");
        read_check(8'h20, 32'h0, shell_pkg::RESP_SLVERR, "unmapped read high");
    endtask

    task automatic test_cmac_loopback();
        shell_pkg::axis_fwd_t pkt[$];
        shell_pkg::axis_fwd_t got[$];
        int                   lens[3] = '{1, 4, 7};
        foreach (lens[i]) begin
            make_packet(lens[i], pkt);
            fork
                send_packet(0, pkt);
                collect_packet(0, 0, got);
            join
            compare_packet(got, pkt, $sformatf("CMAC packet %0d", i));
        end
        read_check(shell_pkg::REG_CMAC_FWD, 32'h3, shell_pkg::RESP_OKAY, "CMAC fwd count");
        read_check(shell_pkg::REG_CMAC_DROP, 32'h0, shell_pkg::RESP_OKAY, "CMAC drop count");
    endtask

    task automatic test_dma_enable();
        shell_pkg::axis_fwd_t pkt[$];
        shell_pkg::axis_fwd_t got[$];
        write_check(shell_pkg::REG_CONTROL, 32'h1, 4'hF, shell_pkg::RESP_OKAY, "DMA disable");
        make_packet(3, pkt);
        send_expect_dropped(1, pkt);
        make_packet(6, pkt);
        send_expect_dropped(1, pkt);
        read_check(shell_pkg::REG_DMA_DROP, 32'h2, shell_pkg::RESP_OKAY, "DMA drop count");
        read_check(shell_pkg::REG_DMA_FWD, 32'h0, shell_pkg::RESP_OKAY, "DMA fwd while off");
        write_check(shell_pkg::REG_CONTROL, 32'h3, 4'hF, shell_pkg::RESP_OKAY, "DMA enable");
        make_packet(5, pkt);
        fork
            send_packet(1, pkt);
            collect_packet(1, 0, got);
        join
        compare_packet(got, pkt, "DMA packet after enable");
        read_check(shell_pkg::REG_DMA_FWD, 32'h1, shell_pkg::RESP_OKAY, "DMA fwd count");
    endtask

    task automatic test_dma_backpressure();
        shell_pkg::axis_fwd_t pkt[$];
        shell_pkg::axis_fwd_t all[$];
        shell_pkg::axis_fwd_t got[$];
        shell_pkg::axis_fwd_t rx[$];
        make_packet(9, pkt);
        all = pkt;
        make_packet(16, pkt);
        all = {all, pkt};
        make_packet(5, pkt);
        all = {all, pkt};
        fork
            send_packet(1, all);
            begin
                repeat (3) begin
                    collect_packet(1, 1, got);
                    rx = {rx, got};
                end
            end
        join
        compare_packet(rx, all, "DMA stream under back-pressure");
        read_check(shell_pkg::REG_DMA_FWD, 32'h4, shell_pkg::RESP_OKAY, "DMA fwd after stream");
    endtask

    task automatic test_enable_mid_packet();
        shell_pkg::axis_fwd_t  pkt[$];
        shell_pkg::axis_fwd_t  got[$];
        shell_pkg::axil_resp_t resp;
        int                    waited;
        make_packet(12, pkt);
        fork
            send_packet(0, pkt);
            collect_packet(0, 0, got);
            begin
                // Clear the enable once the first beat is through
                waited = 0;
                do begin
                    @(posedge clk);
                    waited++;
                    if (waited > WAIT_LIMIT) begin
                        stop_on_timeout("first CMAC output beat");
                    end
                end while (!mon.cmac_tx.tvalid);
                axil_write(shell_pkg::REG_CONTROL, 32'h2, 4'hF, resp);
            end
        join
        check_resp(resp, shell_pkg::RESP_OKAY, "CMAC disable mid packet");
        compare_packet(got, pkt, "CMAC packet in flight");
        read_check(shell_pkg::REG_CONTROL, 32'h2, shell_pkg::RESP_OKAY, "control CMAC off");
        read_check(shell_pkg::REG_CMAC_FWD, 32'h4, shell_pkg::RESP_OKAY, "CMAC fwd in flight");
        make_packet(4, pkt);
        send_expect_dropped(0, pkt);
        read_check(shell_pkg::REG_CMAC_DROP, 32'h1, shell_pkg::RESP_OKAY, "CMAC drop next");
        read_check(shell_pkg::REG_CMAC_FWD, 32'h4, shell_pkg::RESP_OKAY, "CMAC fwd next");
        write_check(shell_pkg::REG_CONTROL, 32'h3, 4'hF, shell_pkg::RESP_OKAY, "control restore");
    endtask

    initial begin
        drv                = '0;
        drv.cmac_tx.tready = 1'b1;
        drv.c2h.tready     = 1'b1;
        rst                = 1'b1;
        repeat (3) @(posedge clk);
        rst <= 1'b0;
        @(posedge clk);

        test_registers();
        test_error_responses();
        test_cmac_loopback();
        test_dma_enable();
        test_dma_backpressure();
        test_enable_mid_packet();

        $display("Errors: %0d mismatches, %0d other failures", mismatch_count, fail_count);
        if (mismatch_count == 0 && fail_count == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule : shell_tb

`default_nettype wire

// ==== source/axil_reg_block.sv ====
`timescale 1ns/100ps
`default_nettype none

module axil_reg_block (
    input  wire logic                  clk,
    input  wire logic                  rst,
    input  wire shell_pkg::axil_fwd_t  axil_fwd,
    output shell_pkg::axil_rev_t       axil_rev,
    output logic                       cmac_enable,
    output logic                       dma_enable,
    input  wire shell_pkg::pkt_count_t cmac_fwd_count,
    input  wire shell_pkg::pkt_count_t cmac_drop_count,
    input  wire shell_pkg::pkt_count_t dma_fwd_count,
    input  wire shell_pkg::pkt_count_t dma_drop_count
);
    logic                  wr_xfer;
    logic                  rd_xfer;
    logic                  wr_ok;
    shell_pkg::axil_addr_t wr_addr;
    shell_pkg::axil_addr_t rd_addr;
    shell_pkg::axil_data_t scratch_q;
    shell_pkg::axil_data_t control_q;
    shell_pkg::axil_data_t rd_data;
    shell_pkg::axil_resp_t rd_resp;
    logic                  bvalid_q;
    logic                  rvalid_q;
    shell_pkg::axil_resp_t bresp_q;
    shell_pkg::axil_data_t rdata_q;
    shell_pkg::axil_resp_t rresp_q;

    function automatic shell_pkg::axil_data_t merge_strb(
        input shell_pkg::axil_data_t old_val,
        input shell_pkg::axil_data_t new_val,
        input shell_pkg::axil_strb_t strb
    );
        shell_pkg::axil_data_t res;
        res = old_val;
        for (int i = 0; i < shell_pkg::AXIL_STRB_WID; i++) begin
            if (strb[i]) begin
                res[8*i +: 8] = new_val[8*i +: 8];
            end
        end
        return res;
    endfunction

    // --------------------
    // Write channel
    // --------------------
    assign wr_xfer = axil_fwd.awvalid && axil_fwd.wvalid && !bvalid_q;
    assign wr_addr = {axil_fwd.awaddr[shell_pkg::AXIL_ADDR_WID-1:2], 2'b00};
    assign wr_ok   = (wr_addr == shell_pkg::REG_SCRATCH) || (wr_addr == shell_pkg::REG_CONTROL);

    always_ff @(posedge clk) begin
        if (rst) begin
            bvalid_q  <= 1'b0;
            scratch_q <= '0;
            control_q <= shell_pkg::CONTROL_RESET;
        end else if (wr_xfer) begin
            bvalid_q <= 1'b1;
            if (wr_addr == shell_pkg::REG_SCRATCH) begin
                scratch_q <= merge_strb(scratch_q, axil_fwd.wdata, axil_fwd.wstrb);
            end
            if (wr_addr == shell_pkg::REG_CONTROL) begin
                control_q <= merge_strb(control_q, axil_fwd.wdata, axil_fwd.wstrb)
                             & shell_pkg::CONTROL_MASK;
            end
        end else if (axil_fwd.bready) begin
            bvalid_q <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (wr_xfer) begin
            bresp_q <= wr_ok ? shell_pkg::RESP_OKAY : shell_pkg::RESP_SLVERR;
        end
    end

    assign cmac_enable = control_q[shell_pkg::CTRL_CMAC_EN];
    assign dma_enable  = control_q[shell_pkg::CTRL_DMA_EN];

    // --------------------
    // Read channel
    // --------------------
    assign rd_xfer = axil_fwd.arvalid && !rvalid_q;
    assign rd_addr = {axil_fwd.araddr[shell_pkg::AXIL_ADDR_WID-1:2], 2'b00};

    always_comb begin
        rd_data = '0;
        rd_resp = shell_pkg::RESP_OKAY;
        case (rd_addr)
            shell_pkg::REG_ID:        rd_data = shell_pkg::SHELL_ID;
            shell_pkg::REG_SCRATCH:   rd_data = scratch_q;
            shell_pkg::REG_CONTROL:   rd_data = control_q;
            shell_pkg::REG_CMAC_FWD:  rd_data = cmac_fwd_count;
            shell_pkg::REG_CMAC_DROP: rd_data = cmac_drop_count;
            shell_pkg::REG_DMA_FWD:   rd_data = dma_fwd_count;
            shell_pkg::REG_DMA_DROP:  rd_data = dma_drop_count;
            default:                  rd_resp = shell_pkg::RESP_SLVERR;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            rvalid_q <= 1'b0;
        end else if (rd_xfer) begin
            rvalid_q <= 1'b1;
        end else if (axil_fwd.rready) begin
            rvalid_q <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (rd_xfer) begin
            rdata_q <= rd_data;
            rresp_q <= rd_resp;
        end
    end

    always_comb begin
        axil_rev.awready = wr_xfer;
        axil_rev.wready  = wr_xfer;
        axil_rev.bvalid  = bvalid_q;
        axil_rev.bresp   = bresp_q;
        axil_rev.arready = !rvalid_q;
        axil_rev.rvalid  = rvalid_q;
        axil_rev.rdata   = rdata_q;
        axil_rev.rresp   = rresp_q;
    end

    a_bvalid_held: assert property (@(posedge clk) disable iff (rst)
        bvalid_q && !axil_fwd.bready |=> bvalid_q && $stable(bresp_q));
    a_rvalid_held: assert property (@(posedge clk) disable iff (rst)
        rvalid_q && !axil_fwd.rready |=> rvalid_q && $stable(rdata_q));

endmodule : axil_reg_block

`default_nettype wire

// ==== source/axis_skid_buffer.sv ====
`timescale 1ns/100ps
`default_nettype none

module axis_skid_buffer (
    input  wire logic                 clk,
    input  wire logic                 rst,
    input  wire shell_pkg::axis_fwd_t in_fwd,
    output shell_pkg::axis_rev_t      in_rev,
    output shell_pkg::axis_fwd_t      out_fwd,
    input  wire shell_pkg::axis_rev_t out_rev
);
    shell_pkg::axis_fwd_t main_q;
    shell_pkg::axis_fwd_t skid_q;
    logic                 main_valid;
    logic                 skid_valid;
    logic                 in_xfer;
    logic                 main_load;

    // Room for a new beat unless the skid slot is taken
    assign in_rev.tready = !skid_valid;
    assign in_xfer       = in_fwd.tvalid && !skid_valid;

    // Main register is free or drains this cycle
    assign main_load = !main_valid || out_rev.tready;

    always_ff @(posedge clk) begin
        if (rst) begin
            main_valid <= 1'b0;
            skid_valid <= 1'b0;
        end else if (main_load) begin
            main_valid <= skid_valid || in_xfer;
            skid_valid <= 1'b0;
        end else if (in_xfer) begin
            skid_valid <= 1'b1;
        end
    end

    // Payload path
    always_ff @(posedge clk) begin
        if (main_load) begin
            main_q <= skid_valid ? skid_q : in_fwd;
        end
        if (!main_load && in_xfer) begin
            skid_q <= in_fwd;
        end
    end

    always_comb begin
        out_fwd        = main_q;
        out_fwd.tvalid = main_valid;
    end

    a_out_stable: assert property (@(posedge clk) disable iff (rst)
        out_fwd.tvalid && !out_rev.tready |=> $stable(out_fwd));

endmodule : axis_skid_buffer

`default_nettype wire

// ==== source/pkt_path.sv ====
`timescale 1ns/100ps
`default_nettype none

module pkt_path (
    input  wire logic                 clk,
    input  wire logic                 rst,
    input  wire logic                 enable,
    input  wire shell_pkg::axis_fwd_t in_fwd,
    output shell_pkg::axis_rev_t      in_rev,
    output shell_pkg::axis_fwd_t      out_fwd,
    input  wire shell_pkg::axis_rev_t out_rev,
    output shell_pkg::pkt_count_t     fwd_count,
    output shell_pkg::pkt_count_t     drop_count
);
    typedef enum logic {
        IDLE,
        IN_PACKET
    } state_t;

    state_t               state;
    logic                 fwd_q;
    logic                 pass;
    logic                 in_xfer;
    logic                 pkt_done;
    shell_pkg::axis_fwd_t sb_in_fwd;
    shell_pkg::axis_rev_t sb_in_rev;

    // Live enable on the first beat, latched decision afterwards
    assign pass = (state == IDLE) ? enable : fwd_q;

    always_comb begin
        sb_in_fwd        = in_fwd;
        sb_in_fwd.tvalid = in_fwd.tvalid && pass;
    end

    // Dropped beats are always accepted
    assign in_rev.tready = pass ? sb_in_rev.tready : 1'b1;

    assign in_xfer  = in_fwd.tvalid && in_rev.tready;
    assign pkt_done = in_xfer && in_fwd.tlast;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= IDLE;
            fwd_q <= 1'b0;
        end else if (in_xfer) begin
            fwd_q <= pass;
            state <= in_fwd.tlast ? IDLE : IN_PACKET;
        end
    end

    // Packet statistics
    always_ff @(posedge clk) begin
        if (rst) begin
            fwd_count  <= '0;
            drop_count <= '0;
        end else if (pkt_done) begin
            if (pass) begin
                fwd_count <= fwd_count + 1'b1;
            end else begin
                drop_count <= drop_count + 1'b1;
            end
        end
    end

    axis_skid_buffer u_skid (
        .clk     ( clk ),
        .rst     ( rst ),
        .in_fwd  ( sb_in_fwd ),
        .in_rev  ( sb_in_rev ),
        .out_fwd ( out_fwd ),
        .out_rev ( out_rev )
    );

    a_decision_held: assert property (@(posedge clk) disable iff (rst)
        (state == IN_PACKET) && !pkt_done |=> (state == IN_PACKET) && $stable(fwd_q));

endmodule : pkt_path

`default_nettype wire

// ==== source/shell_adapter.sv ====
`timescale 1ns/100ps
`default_nettype none

module shell_adapter (
    input  wire logic                                    clk,
    input  wire logic                                    rst,
    input  wire logic [shell_pkg::SHELL_TO_CORE_WID-1:0] shell_to_core,
    output wire logic [shell_pkg::CORE_TO_SHELL_WID-1:0] core_to_shell
);
    // Flat shell vectors as structs
    shell_pkg::shell_to_core_t shell_to_core_s;
    shell_pkg::core_to_shell_t core_to_shell_s;

    assign shell_to_core_s = shell_to_core;
    assign core_to_shell   = core_to_shell_s;

    logic                  cmac_enable;
    logic                  dma_enable;
    shell_pkg::pkt_count_t cmac_fwd_count;
    shell_pkg::pkt_count_t cmac_drop_count;
    shell_pkg::pkt_count_t dma_fwd_count;
    shell_pkg::pkt_count_t dma_drop_count;

    // --------------------
    // AXI-Lite control
    // --------------------
    shell_pkg::axil_fwd_t shell_to_core_axil;
    shell_pkg::axil_rev_t core_to_shell_axil;

    assign shell_to_core_axil   = shell_to_core_s.axil;
    assign core_to_shell_s.axil = core_to_shell_axil;

    axil_reg_block u_regs (
        .clk             ( clk ),
        .rst             ( rst ),
        .axil_fwd        ( shell_to_core_axil ),
        .axil_rev        ( core_to_shell_axil ),
        .cmac_enable     ( cmac_enable ),
        .dma_enable      ( dma_enable ),
        .cmac_fwd_count  ( cmac_fwd_count ),
        .cmac_drop_count ( cmac_drop_count ),
        .dma_fwd_count   ( dma_fwd_count ),
        .dma_drop_count  ( dma_drop_count )
    );

    // --------------------
    // CMAC loopback
    // --------------------
    shell_pkg::axis_rev_t core_to_shell_cmac_rx;
    shell_pkg::axis_fwd_t core_to_shell_cmac_tx;

    assign core_to_shell_s.cmac_rx = core_to_shell_cmac_rx;
    assign core_to_shell_s.cmac_tx = core_to_shell_cmac_tx;

    pkt_path u_cmac_path (
        .clk        ( clk ),
        .rst        ( rst ),
        .enable     ( cmac_enable ),
        .in_fwd     ( shell_to_core_s.cmac_rx ),
        .in_rev     ( core_to_shell_cmac_rx ),
        .out_fwd    ( core_to_shell_cmac_tx ),
        .out_rev    ( shell_to_core_s.cmac_tx ),
        .fwd_count  ( cmac_fwd_count ),
        .drop_count ( cmac_drop_count )
    );

    // --------------------
    // DMA loopback, H2C to C2H
    // --------------------
    shell_pkg::axis_rev_t core_to_shell_h2c;
    shell_pkg::axis_fwd_t core_to_shell_c2h;

    assign core_to_shell_s.h2c = core_to_shell_h2c;
    assign core_to_shell_s.c2h = core_to_shell_c2h;

    pkt_path u_dma_path (
        .clk        ( clk ),
        .rst        ( rst ),
        .enable     ( dma_enable ),
        .in_fwd     ( shell_to_core_s.h2c ),
        .in_rev     ( core_to_shell_h2c ),
        .out_fwd    ( core_to_shell_c2h ),
        .out_rev    ( shell_to_core_s.c2h ),
        .fwd_count  ( dma_fwd_count ),
        .drop_count ( dma_drop_count )
    );

endmodule : shell_adapter

`default_nettype wire

// ==== source/shell_pkg.sv ====
`default_nettype none

package shell_pkg;

    // --------------------
    // AXI4-Lite
    // --------------------
    localparam int AXIL_ADDR_WID = 8;
    localparam int AXIL_DATA_WID = 32;
    localparam int AXIL_STRB_WID = AXIL_DATA_WID / 8;

    typedef logic [AXIL_ADDR_WID-1:0] axil_addr_t;
    typedef logic [AXIL_DATA_WID-1:0] axil_data_t;
    typedef logic [AXIL_STRB_WID-1:0] axil_strb_t;
    typedef logic [2:0]               axil_prot_t;
    typedef logic [1:0]               axil_resp_t;

    localparam axil_resp_t RESP_OKAY   = 2'b00;
    localparam axil_resp_t RESP_SLVERR = 2'b10;

    typedef struct packed {
        logic       awvalid;
        axil_addr_t awaddr;
        axil_prot_t awprot;
        logic       wvalid;
        axil_data_t wdata;
        axil_strb_t wstrb;
        logic       bready;
        logic       arvalid;
        axil_addr_t araddr;
        axil_prot_t arprot;
        logic       rready;
    } axil_fwd_t;

    typedef struct packed {
        logic       awready;
        logic       wready;
        logic       bvalid;
        axil_resp_t bresp;
        logic       arready;
        logic       rvalid;
        axil_data_t rdata;
        axil_resp_t rresp;
    } axil_rev_t;

    // Register map, byte addresses
    localparam axil_addr_t REG_ID        = 8'h00;
    localparam axil_addr_t REG_SCRATCH   = 8'h04;
    localparam axil_addr_t REG_CONTROL   = 8'h08;
    localparam axil_addr_t REG_CMAC_FWD  = 8'h10;
    localparam axil_addr_t REG_CMAC_DROP = 8'h14;
    localparam axil_addr_t REG_DMA_FWD   = 8'h18;
    localparam axil_addr_t REG_DMA_DROP  = 8'h1C;

    localparam axil_data_t SHELL_ID      = 32'h5348_0001;
    localparam axil_data_t CONTROL_MASK  = 32'h0000_0003;
    localparam axil_data_t CONTROL_RESET = 32'h0000_0003;
    localparam int         CTRL_CMAC_EN  = 0;
    localparam int         CTRL_DMA_EN   = 1;

    // --------------------
    // Streams
    // --------------------
    localparam int STREAM_DATA_BYTE_WID = 8;
    localparam int PKT_COUNT_WID        = 32;

    typedef logic [STREAM_DATA_BYTE_WID*8-1:0] stream_data_t;
    typedef logic [STREAM_DATA_BYTE_WID-1:0]   stream_keep_t;
    typedef logic [PKT_COUNT_WID-1:0]          pkt_count_t;

    typedef struct packed {
        logic         tvalid;
        stream_data_t tdata;
        stream_keep_t tkeep;
        logic         tlast;
        logic         tuser;   // error flag
    } axis_fwd_t;

    typedef struct packed {
        logic tready;
    } axis_rev_t;

    // --------------------
    // Shell boundary
    // --------------------
    typedef struct packed {
        axil_fwd_t axil;
        axis_fwd_t cmac_rx;
        axis_rev_t cmac_tx;
        axis_fwd_t h2c;
        axis_rev_t c2h;
    } shell_to_core_t;

    typedef struct packed {
        axil_rev_t axil;
        axis_rev_t cmac_rx;
        axis_fwd_t cmac_tx;
        axis_rev_t h2c;
        axis_fwd_t c2h;
    } core_to_shell_t;

    localparam int SHELL_TO_CORE_WID = $bits(shell_to_core_t);
    localparam int CORE_TO_SHELL_WID = $bits(core_to_shell_t);

endpackage : shell_pkg

`default_nettype wire

// ==== src.f ====
source/shell_pkg.sv
source/axis_skid_buffer.sv
source/pkt_path.sv
source/axil_reg_block.sv
source/shell_adapter.sv
dv/shell_tb.sv
